/* ccc_pkg.sv */
// ###########################################################################
// shared definitions for the broadcast CCC target sequencer
// receive engine mode codes, register file addresses, CCC ids
// and the CCC code union
// ###########################################################################
package ccc_pkg;

  // receive engine modes, encodings agreed with the rx engine
  typedef enum logic [3:0] {
    PREAMBLE         = 4'b0001,  // single preamble bit
    DESER_DEF        = 4'b0010,  // defining byte or data byte
    CRC_VALUE        = 4'b0011,  // 5 bit crc word
    CHECK_PARITY     = 4'b0100,  // two parity bits of a word
    TOKEN_CRC        = 4'b0101,  // crc token 4'hC
    CCC_VALUE        = 4'b0110,  // command code byte
    SPECIAL_PREAMBLE = 4'b1001   // preamble ahead of the crc word
  } rx_mode_e;

  // command code fields
  typedef struct packed {
    logic       direct;  // set for direct ccc
    logic [6:0] id;
  } ccc_fields_s;

  // one byte, read raw or split into direct flag and id
  typedef union packed {
    logic [7:0]  raw;
    ccc_fields_s fields;
  } ccc_code_u;

  // register file map
  localparam logic [7:0] REGF_DEF_ADDR = 8'hFF;  // scratch, defining byte lands here
  localparam logic [7:0] REGF_MWL_ADDR = 8'h00;  // mwl msb, lsb at +1
  localparam logic [7:0] REGF_MRL_ADDR = 8'h02;  // mrl msb, lsb at +1

  // broadcast codes with a register target
  localparam logic [6:0] CCC_SETMWL = 7'h09;
  localparam logic [6:0] CCC_SETMRL = 7'h0A;

endpackage

/* ccc_regf_port.sv */
// ###########################################################################
// register file side of the CCC target
// holds the command code, decodes SETMWL/SETMRL support,
// counts data bytes and drives the write strobe and address
// ###########################################################################
`timescale 1ns/10ps

module ccc_regf_port (
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_ccc_capture,     // CCC_VALUE done
  input  logic [7:0] i_ccc_value,       // valid with capture
  input  logic       i_def_byte_done,
  input  logic       i_data_byte_done,
  output logic       o_ccc_supported,
  output logic       o_last_byte,
  output logic       o_regf_wr_en,
  output logic [7:0] o_regf_addr
);

  ccc_pkg::ccc_code_u ccc_q;     // captured code
  ccc_pkg::ccc_code_u ccc_cur;   // code as seen this cycle
  logic               byte_cnt;  // 0 first data byte, 1 second
  logic               is_mwl;
  logic               is_mrl;
  logic [7:0]         data_base;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      ccc_q.raw <= 8'h00;
      byte_cnt  <= 1'b0;
    end else begin
      if (i_ccc_capture) begin
        ccc_q.raw <= i_ccc_value;
        byte_cnt  <= 1'b0;  // new command, restart count
      end else if (i_data_byte_done) begin
        byte_cnt <= ~byte_cnt;
      end
    end
  end

  // bypass so the FSM sees support in the capture cycle itself
  assign ccc_cur.raw = i_ccc_capture ? i_ccc_value : ccc_q.raw;

  assign is_mwl = (ccc_cur.fields.id == ccc_pkg::CCC_SETMWL);
  assign is_mrl = (ccc_cur.fields.id == ccc_pkg::CCC_SETMRL);

  // broadcast only, direct codes are not handled here
  assign o_ccc_supported = !ccc_cur.fields.direct && (is_mwl || is_mrl);
  assign o_last_byte     = byte_cnt;

  assign data_base = is_mrl ? ccc_pkg::REGF_MRL_ADDR : ccc_pkg::REGF_MWL_ADDR;

  assign o_regf_wr_en = i_def_byte_done | i_data_byte_done;

  always_comb begin
    if (i_def_byte_done) begin
      o_regf_addr = ccc_pkg::REGF_DEF_ADDR;
    end else if (i_data_byte_done) begin
      o_regf_addr = data_base + {7'd0, byte_cnt};  // msb then lsb
    end else begin
      o_regf_addr = 8'h00;  // idle bus
    end
  end

endmodule

/* ccc_sequencer.sv */
// ###########################################################################
// broadcast CCC frame FSM for the HDR-DDR target
// launches rx/tx engine modes, strobes the register file port
// and flags the end of a frame
// ###########################################################################
`timescale 1ns/10ps

module ccc_sequencer (
  input  logic              i_sys_clk,
  input  logic              i_sys_rst,
  input  logic              i_engine_en,       // level, frame may start
  input  logic              i_tx_mode_done,    // ack sent
  input  logic              i_rx_mode_done,    // rx mode finished
  input  logic              i_rx_error,        // valid with rx done
  input  logic              i_preamble_bit,    // valid with preamble done
  input  logic              i_restart_done,
  input  logic              i_exit_done,
  input  logic              i_ccc_supported,   // from regf port
  input  logic              i_last_byte,       // second data byte pending
  output logic              o_tx_en,
  output logic              o_rx_en,
  output ccc_pkg::rx_mode_e o_rx_mode,
  output logic              o_engine_done,
  output logic              o_ccc_capture,
  output logic              o_def_byte_done,
  output logic              o_data_byte_done
);

  typedef enum logic [3:0] {
    IDLE             = 4'd0,
    PRE_CMD          = 4'd1,
    ACK              = 4'd2,
    CHECK_CCC        = 4'd3,
    DEF_DATA         = 4'd4,
    CHECK_PARITY     = 4'd5,
    DATA             = 4'd6,
    SPECIAL_PREAMBLE = 4'd7,
    TOKEN_CRC        = 4'd8,
    CRC_VALUE        = 4'd9,
    RESTART_EXIT     = 4'd10
  } state_e;

  state_e cur_state;
  state_e nxt_state;
  logic   data_phase;      // low in command word, high in data word
  logic   data_phase_nxt;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      cur_state  <= IDLE;
      data_phase <= 1'b0;
    end else begin
      cur_state  <= nxt_state;
      data_phase <= data_phase_nxt;
    end
  end

  // every launch or strobe fires in the cycle of the done that causes it
  always_comb begin
    nxt_state        = cur_state;
    data_phase_nxt   = data_phase;
    o_tx_en          = 1'b0;
    o_rx_en          = 1'b0;
    o_rx_mode        = ccc_pkg::rx_mode_e'(4'd0);  // zero when not launched
    o_engine_done    = 1'b0;
    o_ccc_capture    = 1'b0;
    o_def_byte_done  = 1'b0;
    o_data_byte_done = 1'b0;

    case (cur_state)
      IDLE: begin
        data_phase_nxt = 1'b0;  // new frame starts in command word
        if (i_engine_en) begin
          o_rx_en   = 1'b1;
          o_rx_mode = ccc_pkg::PREAMBLE;
          nxt_state = PRE_CMD;
        end
      end

      PRE_CMD: begin
        if (!i_engine_en) begin
          nxt_state = IDLE;  // quiet drop, no done
        end else if (i_rx_mode_done) begin
          if (i_preamble_bit) begin
            o_tx_en   = 1'b1;  // drive the ack
            nxt_state = ACK;
          end else begin
            o_engine_done = 1'b1;  // reject
            nxt_state     = IDLE;
          end
        end
      end

      ACK: begin
        if (i_tx_mode_done) begin
          o_rx_en = 1'b1;
          if (data_phase) begin
            o_rx_mode = ccc_pkg::DESER_DEF;  // first data byte
            nxt_state = DATA;
          end else begin
            o_rx_mode = ccc_pkg::CCC_VALUE;
            nxt_state = CHECK_CCC;
          end
        end
      end

      CHECK_CCC: begin
        if (i_rx_mode_done) begin
          o_ccc_capture = 1'b1;  // supported is valid this cycle
          if (i_ccc_supported) begin
            o_rx_en   = 1'b1;
            o_rx_mode = ccc_pkg::DESER_DEF;
            nxt_state = DEF_DATA;
          end else begin
            o_engine_done = 1'b1;
            nxt_state     = IDLE;
          end
        end
      end

      DEF_DATA: begin
        if (i_rx_mode_done) begin
          o_def_byte_done = 1'b1;  // defining byte to scratch
          o_rx_en         = 1'b1;
          o_rx_mode       = ccc_pkg::CHECK_PARITY;
          nxt_state       = CHECK_PARITY;
        end
      end

      CHECK_PARITY: begin
        if (i_rx_mode_done) begin
          if (i_rx_error) begin
            o_engine_done = 1'b1;
            nxt_state     = IDLE;
          end else if (data_phase) begin
            o_rx_en   = 1'b1;
            o_rx_mode = ccc_pkg::SPECIAL_PREAMBLE;
            nxt_state = SPECIAL_PREAMBLE;
          end else begin
            // command word done, data word follows
            data_phase_nxt = 1'b1;
            o_rx_en        = 1'b1;
            o_rx_mode      = ccc_pkg::PREAMBLE;
            nxt_state      = PRE_CMD;
          end
        end
      end

      DATA: begin
        if (i_rx_mode_done) begin
          o_data_byte_done = 1'b1;
          o_rx_en          = 1'b1;
          if (i_last_byte) begin
            o_rx_mode = ccc_pkg::CHECK_PARITY;
            nxt_state = CHECK_PARITY;
          end else begin
            o_rx_mode = ccc_pkg::DESER_DEF;  // second byte
          end
        end
      end

      SPECIAL_PREAMBLE: begin
        if (i_rx_mode_done) begin
          o_rx_en   = 1'b1;
          o_rx_mode = ccc_pkg::TOKEN_CRC;
          nxt_state = TOKEN_CRC;
        end
      end

      TOKEN_CRC: begin
        if (i_rx_mode_done) begin
          if (i_rx_error) begin
            o_engine_done = 1'b1;
            nxt_state     = IDLE;
          end else begin
            o_rx_en   = 1'b1;
            o_rx_mode = ccc_pkg::CRC_VALUE;
            nxt_state = CRC_VALUE;
          end
        end
      end

      CRC_VALUE: begin
        if (i_rx_mode_done) begin
          if (i_rx_error) begin
            o_engine_done = 1'b1;
            nxt_state     = IDLE;
          end else begin
            nxt_state = RESTART_EXIT;  // bus owns the next step
          end
        end
      end

      RESTART_EXIT: begin
        if (i_restart_done) begin
          data_phase_nxt = 1'b0;  // next word is a command word
          o_rx_en        = 1'b1;
          o_rx_mode      = ccc_pkg::PREAMBLE;
          nxt_state      = PRE_CMD;
        end else if (i_exit_done) begin
          o_engine_done = 1'b1;
          nxt_state     = IDLE;
        end
      end

      default: nxt_state = IDLE;
    endcase
  end

endmodule

/* ccc_target.sv */
// ###########################################################################
// broadcast CCC target top level
// frame sequencer plus register file port
// ###########################################################################
`timescale 1ns/10ps

module ccc_target (
  input  logic              i_sys_clk,
  input  logic              i_sys_rst,
  input  logic              i_engine_en,
  input  logic              i_tx_mode_done,
  input  logic              i_rx_mode_done,
  input  logic              i_rx_error,
  input  logic              i_preamble_bit,
  input  logic [7:0]        i_ccc_value,
  input  logic              i_restart_done,
  input  logic              i_exit_done,
  output logic              o_tx_en,
  output logic              o_rx_en,
  output ccc_pkg::rx_mode_e o_rx_mode,
  output logic              o_engine_done,
  output logic [7:0]        o_regf_addr,
  output logic              o_regf_wr_en
);

  logic ccc_capture;     // code byte received
  logic def_byte_done;   // defining byte received
  logic data_byte_done;  // SETMWL/SETMRL payload byte received
  logic ccc_supported;
  logic last_byte;

  ccc_sequencer u_sequencer (
    .i_sys_clk        (i_sys_clk),
    .i_sys_rst        (i_sys_rst),
    .i_engine_en      (i_engine_en),
    .i_tx_mode_done   (i_tx_mode_done),
    .i_rx_mode_done   (i_rx_mode_done),
    .i_rx_error       (i_rx_error),
    .i_preamble_bit   (i_preamble_bit),
    .i_restart_done   (i_restart_done),
    .i_exit_done      (i_exit_done),
    .i_ccc_supported  (ccc_supported),
    .i_last_byte      (last_byte),
    .o_tx_en          (o_tx_en),
    .o_rx_en          (o_rx_en),
    .o_rx_mode        (o_rx_mode),
    .o_engine_done    (o_engine_done),
    .o_ccc_capture    (ccc_capture),
    .o_def_byte_done  (def_byte_done),
    .o_data_byte_done (data_byte_done)
  );

  ccc_regf_port u_regf_port (
    .i_sys_clk        (i_sys_clk),
    .i_sys_rst        (i_sys_rst),
    .i_ccc_capture    (ccc_capture),
    .i_ccc_value      (i_ccc_value),
    .i_def_byte_done  (def_byte_done),
    .i_data_byte_done (data_byte_done),
    .o_ccc_supported  (ccc_supported),
    .o_last_byte      (last_byte),
    .o_regf_wr_en     (o_regf_wr_en),
    .o_regf_addr      (o_regf_addr)
  );

endmodule

/* list.f */
ccc_pkg.sv
ccc_sequencer.sv
ccc_regf_port.sv
ccc_target.sv
tb_ccc_engine_model.sv
tb_ccc_target.sv

/* run.sh */
#!/bin/bash
# build the CCC target testbench with Verilator, run it and check the log
cd "$(dirname "$0")" && rm -rf obj_dir sim.log &&
  verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_ccc_target -f list.f -o tb_sim &&
  ./obj_dir/tb_sim 2>&1 | tee sim.log &&
  grep -q "^Test completed successfully$" sim.log &&
  echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_ccc_engine_model.sv */
// ###########################################################################
// behavioral rx and tx engine model for the CCC target testbench
// answers every launch with a done pulse after 1 to 4 cycles
// ###########################################################################
`timescale 1ns/10ps

module tb_ccc_engine_model (
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_engine_en,     // low between frames, clears error count
  input  logic       i_rx_en,
  input  logic [3:0] i_rx_mode,
  input  logic       i_tx_en,
  input  logic       i_cfg_preamble,  // preamble bit to return
  input  logic [7:0] i_cfg_code,      // code byte to return
  input  logic [3:0] i_err_mode,      // 0 for no error
  input  logic [1:0] i_err_nth,       // launch of that mode that fails
  output logic       o_rx_mode_done,
  output logic       o_rx_error,
  output logic       o_preamble_bit,
  output logic [7:0] o_ccc_value,
  output logic       o_tx_mode_done
);

  logic       rx_req;      // launch seen at last rising edge
  logic       tx_req;
  logic       rx_err_req;  // that launch is the faulty one
  logic [1:0] err_cnt;
  logic       pre_q;
  logic [7:0] code_q;
  logic [2:0] rx_left;     // cycles until rx done, 0 idle
  logic [2:0] rx_left_n;
  logic [2:0] tx_left;
  logic [2:0] tx_left_n;
  logic       rx_err_pend;

  always @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      rx_req     <= 1'b0;
      tx_req     <= 1'b0;
      rx_err_req <= 1'b0;
      err_cnt    <= 2'd0;
      pre_q      <= 1'b0;
      code_q     <= 8'h00;
    end else begin
      rx_req     <= i_rx_en;
      tx_req     <= i_tx_en;
      rx_err_req <= i_rx_en && (i_rx_mode == i_err_mode) && (err_cnt + 2'd1 == i_err_nth);
      pre_q      <= i_cfg_preamble;
      code_q     <= i_cfg_code;
      if (!i_engine_en) begin
        err_cnt <= 2'd0;
      end else if (i_rx_en && (i_rx_mode == i_err_mode)) begin
        err_cnt <= err_cnt + 2'd1;  // count launches of the faulty mode
      end
    end
  end

  // done pulses change on the falling edge only
  always @(negedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_rx_mode_done <= 1'b0;
      o_rx_error     <= 1'b0;
      o_preamble_bit <= 1'b0;
      o_ccc_value    <= 8'h00;
      o_tx_mode_done <= 1'b0;
      rx_left        = 3'd0;
      tx_left        = 3'd0;
      rx_err_pend    = 1'b0;
    end else begin
      o_rx_mode_done <= 1'b0;
      o_rx_error     <= 1'b0;
      o_tx_mode_done <= 1'b0;
      o_preamble_bit <= pre_q;
      o_ccc_value    <= code_q;
      rx_left_n = rx_req ? 3'(1 + $urandom % 4) : rx_left;  // 1 to 4 cycles
      tx_left_n = tx_req ? 3'(1 + $urandom % 4) : tx_left;
      if (rx_req) rx_err_pend = rx_err_req;
      if (rx_left_n == 3'd1) begin
        o_rx_mode_done <= 1'b1;
        o_rx_error     <= rx_err_pend;
      end
      if (tx_left_n == 3'd1) o_tx_mode_done <= 1'b1;
      rx_left = (rx_left_n != 3'd0) ? rx_left_n - 3'd1 : 3'd0;
      tx_left = (tx_left_n != 3'd0) ? tx_left_n - 3'd1 : 3'd0;
    end
  end

endmodule

/* tb_ccc_target.sv */
// ###########################################################################
// testbench top for the broadcast CCC target
// clock, reset, frame scenarios and checking assertions
// ###########################################################################
`timescale 1ns/10ps

module tb_ccc_target;

  logic               sys_clk;
  logic               sys_rst;
  logic               engine_en;
  logic               tx_mode_done;
  logic               rx_mode_done;
  logic               rx_error;
  logic               preamble_bit;
  logic [7:0]         ccc_value;
  logic               restart_done;
  logic               exit_done;
  logic               tx_en;
  logic               rx_en;
  ccc_pkg::rx_mode_e  rx_mode;
  logic               engine_done;
  logic [7:0]         regf_addr;
  logic               regf_wr_en;
  logic               cfg_preamble;
  ccc_pkg::ccc_code_u cfg_code;
  logic [3:0]         err_mode;      // 0 for a clean frame
  logic [1:0]         err_nth;
  logic [3:0]         rx_log[$];     // launched rx modes
  logic [7:0]         wr_log[$];     // register file addresses
  int                 tx_cnt;
  int                 done_cnt;
  logic               crc_ok;        // good crc done, waiting for restart
  logic               done_on_err;
  ccc_pkg::ccc_code_u code;

  // launch order of a complete SETMWL/SETMRL frame
  localparam logic [3:0] FULL_SEQ [11] = '{
    ccc_pkg::PREAMBLE, ccc_pkg::CCC_VALUE, ccc_pkg::DESER_DEF, ccc_pkg::CHECK_PARITY,
    ccc_pkg::PREAMBLE, ccc_pkg::DESER_DEF, ccc_pkg::DESER_DEF, ccc_pkg::CHECK_PARITY,
    ccc_pkg::SPECIAL_PREAMBLE, ccc_pkg::TOKEN_CRC, ccc_pkg::CRC_VALUE
  };

  ccc_target uut (
    .i_sys_clk      (sys_clk),
    .i_sys_rst      (sys_rst),
    .i_engine_en    (engine_en),
    .i_tx_mode_done (tx_mode_done),
    .i_rx_mode_done (rx_mode_done),
    .i_rx_error     (rx_error),
    .i_preamble_bit (preamble_bit),
    .i_ccc_value    (ccc_value),
    .i_restart_done (restart_done),
    .i_exit_done    (exit_done),
    .o_tx_en        (tx_en),
    .o_rx_en        (rx_en),
    .o_rx_mode      (rx_mode),
    .o_engine_done  (engine_done),
    .o_regf_addr    (regf_addr),
    .o_regf_wr_en   (regf_wr_en)
  );

  tb_ccc_engine_model u_engines (
    .i_sys_clk      (sys_clk),
    .i_sys_rst      (sys_rst),
    .i_engine_en    (engine_en),
    .i_rx_en        (rx_en),
    .i_rx_mode      (rx_mode),
    .i_tx_en        (tx_en),
    .i_cfg_preamble (cfg_preamble),
    .i_cfg_code     (cfg_code.raw),
    .i_err_mode     (err_mode),
    .i_err_nth      (err_nth),
    .o_rx_mode_done (rx_mode_done),
    .o_rx_error     (rx_error),
    .o_preamble_bit (preamble_bit),
    .o_ccc_value    (ccc_value),
    .o_tx_mode_done (tx_mode_done)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;  // 4 ns period
  end

  task automatic check_value(input string name, input int exp_val, input int act_val);
    assert (exp_val == act_val) else begin
      $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic clear_logs;
    rx_log.delete();
    wr_log.delete();
    tx_cnt      = 0;
    done_cnt    = 0;
    done_on_err = 1'b0;
    crc_ok      = 1'b0;
  endtask

  // called right after the falling edge drives
  task automatic sample_outputs;
    #1;  // falling edge updates settled
    crc_ok = rx_mode_done && !rx_error && rx_log.size() > 0 &&
             rx_log[$] == ccc_pkg::CRC_VALUE;
    if (engine_done) done_on_err = rx_mode_done && rx_error;
    if (rx_en) rx_log.push_back(rx_mode);
    if (regf_wr_en) wr_log.push_back(regf_addr);
    if (tx_en) tx_cnt++;
    if (engine_done) done_cnt++;
  endtask

  task automatic next_cycle;
    @(negedge sys_clk);
    restart_done = 1'b0;  // bus pulses last one cycle
    exit_done    = 1'b0;
    sample_outputs();
  endtask

  task automatic start_frame(input logic pre, input logic [7:0] cc, input logic [3:0] emode,
                             input logic [1:0] enth);
    clear_logs();
    @(negedge sys_clk);
    cfg_preamble = pre;
    cfg_code.raw = cc;
    err_mode     = emode;
    err_nth      = enth;
    engine_en    = 1'b1;
    sample_outputs();
  endtask

  // ends on o_engine_done or on a good crc value
  task automatic wait_frame_end;
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!engine_done && !crc_ok && n < 300);
    if (!engine_done && !crc_ok) begin
      $display("Timeout: the frame did not end within 300 cycles");
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // drop the enable and make sure nothing new is launched
  task automatic end_frame;
    int n_rx;
    n_rx = rx_log.size();
    @(negedge sys_clk);
    engine_en    = 1'b0;
    restart_done = 1'b0;
    exit_done    = 1'b0;
    sample_outputs();
    repeat (6) next_cycle();
    check_value("o_rx_en launches after frame end", n_rx, rx_log.size());
  endtask

  task automatic check_full_frame(input logic [7:0] base);
    check_value("o_engine_done pulses", 0, done_cnt);
    check_value("o_rx_en launches", 11, rx_log.size());
    for (int i = 0; i < 11; i++) begin
      check_value($sformatf("o_rx_mode[%0d]", i), int'(FULL_SEQ[i]), int'(rx_log[i]));
    end
    check_value("o_regf_wr_en writes", 3, wr_log.size());
    check_value("o_regf_addr[0]", int'(ccc_pkg::REGF_DEF_ADDR), int'(wr_log[0]));
    check_value("o_regf_addr[1]", int'(base), int'(wr_log[1]));
    check_value("o_regf_addr[2]", int'(base) + 1, int'(wr_log[2]));
  endtask

  // reject before any write, n_tx is 0 for a zero preamble
  task automatic run_short_frame(input logic pre, input logic [7:0] cc, input int n_tx,
                                 input logic [3:0] last_mode);
    start_frame(pre, cc, 4'd0, 2'd0);
    wait_frame_end();
    check_value("o_engine_done pulses", 1, done_cnt);
    check_value("o_tx_en pulses", n_tx, tx_cnt);
    check_value("o_rx_en launches", n_tx + 1, rx_log.size());
    check_value("last o_rx_mode", int'(last_mode), int'(rx_log[$]));
    check_value("o_regf_wr_en writes", 0, wr_log.size());
    end_frame();
  endtask

  task automatic run_error_frame(input logic [3:0] emode, input logic [1:0] enth,
                                 input int n_rx);
    start_frame(1'b1, {1'b0, ccc_pkg::CCC_SETMWL}, emode, enth);
    wait_frame_end();
    check_value("o_engine_done pulses", 1, done_cnt);
    check_value("i_rx_error with o_engine_done", 1, int'(done_on_err));
    check_value("o_rx_en launches", n_rx, rx_log.size());
    check_value("last o_rx_mode", int'(emode), int'(rx_log[$]));
    end_frame();
  endtask

  initial begin
    void'($urandom(71));
    sys_rst      = 1'b0;
    engine_en    = 1'b0;
    restart_done = 1'b0;
    exit_done    = 1'b0;
    cfg_preamble = 1'b1;
    cfg_code.raw = 8'h00;
    err_mode     = 4'd0;
    err_nth      = 2'd0;
    clear_logs();
    repeat (2) @(negedge sys_clk);
    sys_rst = 1'b1;

    // quiet after reset with the engine disabled
    repeat (5) begin
      next_cycle();
      check_value("o_rx_en", 0, int'(rx_en));
      check_value("o_tx_en", 0, int'(tx_en));
      check_value("o_regf_wr_en", 0, int'(regf_wr_en));
      check_value("o_engine_done", 0, int'(engine_done));
    end

    start_frame(1'b1, {1'b0, ccc_pkg::CCC_SETMWL}, 4'd0, 2'd0);
    wait_frame_end();
    check_full_frame(ccc_pkg::REGF_MWL_ADDR);

    // restart goes straight into a SETMRL frame
    clear_logs();
    @(negedge sys_clk);
    cfg_code.raw = {1'b0, ccc_pkg::CCC_SETMRL};
    restart_done = 1'b1;
    sample_outputs();
    check_value("o_rx_en launches on restart", 1, rx_log.size());
    check_value("o_rx_mode on restart", int'(ccc_pkg::PREAMBLE), int'(rx_log[0]));
    wait_frame_end();
    check_full_frame(ccc_pkg::REGF_MRL_ADDR);

    // exit while waiting after the crc
    clear_logs();
    @(negedge sys_clk);
    exit_done = 1'b1;
    sample_outputs();
    check_value("o_engine_done on exit", 1, done_cnt);
    end_frame();
    check_value("o_rx_en launches after exit", 0, rx_log.size());

    do begin
      code.raw = 8'($urandom);
    end while (!code.fields.direct && (code.fields.id == ccc_pkg::CCC_SETMWL ||
                                       code.fields.id == ccc_pkg::CCC_SETMRL));
    run_short_frame(1'b1, code.raw, 1, ccc_pkg::CCC_VALUE);
    run_short_frame(1'b1, 8'h89, 1, ccc_pkg::CCC_VALUE);  // direct SETMWL
    run_short_frame(1'b0, {1'b0, ccc_pkg::CCC_SETMWL}, 0, ccc_pkg::PREAMBLE);

    run_error_frame(ccc_pkg::CHECK_PARITY, 2'd2, 8);  // data word parity
    run_error_frame(ccc_pkg::TOKEN_CRC, 2'd1, 10);
    run_error_frame(ccc_pkg::CRC_VALUE, 2'd1, 11);

    $display("Test completed successfully");
    $finish;
  end

endmodule
